// File: mbfPkg.sv
package mbfPkg;

    // truth table of a monotone function of seven variables
    typedef logic [127:0] mbf_t;

    // first-stage partner of variable 0, 0..6
    typedef logic [2:0] permut7_t;

    // second-stage partner of variable 1, 0..5 stands for variable p6+1
    typedef logic [2:0] permut6_t;

    localparam int fifoDepth = 8; // bots in the buffer, also the initial credits

    typedef logic [3:0] creditCount_t; // 0..fifoDepth
    typedef logic [$clog2(fifoDepth)-1:0] fifoPtr_t;

    // a series starts at these indices and counts down to (0,0)
    localparam permut7_t p7First = 3'd6;
    localparam permut6_t p6First = 3'd5;

    // producer to buffer
    typedef struct packed {
        mbf_t bot;
        logic valid;
    } botLink_t;

    typedef enum logic {
        idle,
        permuting
    } genState_t;

    // exchange variables a and b of truth table f
    // output bit i takes input bit j, where j is i with bits a and b swapped
    function automatic mbf_t varSwap(
        input mbf_t       f,
        input logic [2:0] a,
        input logic [2:0] b
    );
        mbf_t       result;
        logic [6:0] src;
        for (int i = 0; i < 128; i++) begin
            src = 7'(i);
            src[a] = i[b];
            src[b] = i[a];
            result[i] = f[src];
        end
        return result;
    endfunction

endpackage

// File: botIngress.sv
`timescale 1ns/1ns

module botIngress (
    input  logic                clk,
    input  logic                rst,
    input  mbfPkg::mbf_t        inputBot,
    input  logic                writeInputBot,
    input  logic                creditReturn,
    output mbfPkg::botLink_t    link,
    output logic                hasSpaceForNextBot
);

    mbfPkg::creditCount_t credits; // free entries left in the buffer
    logic accept;

    // writes without a credit are dropped
    assign accept = writeInputBot && (credits != '0);
    assign hasSpaceForNextBot = (credits != '0);

    always_ff @(posedge clk) begin
        if (accept) begin
            link.bot <= inputBot;
        end
        if (rst) begin
            link.valid <= 1'b0;
        end else begin
            link.valid <= accept; // on the link one cycle after the write
        end
    end

    // take and return can meet in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= mbfPkg::creditCount_t'(mbfPkg::fifoDepth);
        end else begin
            case ({accept, creditReturn})
                2'b10:   credits <= credits - 4'd1;
                2'b01:   credits <= credits + 4'd1;
                default: credits <= credits;     // none, or both cancel
            endcase
        end
    end

endmodule

// File: botFifo.sv
`timescale 1ns/1ns

module botFifo (
    input  logic                clk,
    input  logic                rst,
    input  mbfPkg::botLink_t    link,
    input  logic                pop,
    output mbfPkg::mbf_t        head,
    output logic                notEmpty,
    output logic                creditReturn
);

    mbfPkg::mbf_t         mem [mbfPkg::fifoDepth];
    mbfPkg::fifoPtr_t     wrPtr;
    mbfPkg::fifoPtr_t     rdPtr;
    mbfPkg::creditCount_t count;
    logic push;

    // space is guaranteed by the credits held upstream
    assign push = link.valid;

    assign head = mem[rdPtr]; // first word falls through
    assign notEmpty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= link.bot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == mbfPkg::fifoPtr_t'(mbfPkg::fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == mbfPkg::fifoPtr_t'(mbfPkg::fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: count <= count;
            endcase
            creditReturn <= pop; // one credit per freed entry
        end
    end

endmodule

// File: permute67.sv
`timescale 1ns/1ns

module permute67 (
    input  logic                clk,
    input  mbfPkg::mbf_t        bot,
    input  mbfPkg::permut7_t    p7,
    input  mbfPkg::permut6_t    p6,
    input  logic                validIn,
    input  logic                lastIn,
    output mbfPkg::mbf_t        outputBot,
    output logic                outputBotValid,
    output logic                botSeriesFinished
);

    // stage one results
    mbfPkg::mbf_t     s1Bot;
    mbfPkg::permut6_t p6D; // p6 delayed to line up with s1Bot
    logic             validD;
    logic             lastD;

    // stage one swaps variable 0 with variable p7
    always_ff @(posedge clk) begin
        s1Bot  <= mbfPkg::varSwap(bot, 3'd0, p7);
        p6D    <= p6;
        validD <= validIn;
        lastD  <= lastIn;
    end

    // stage two swaps variable 1 with variable p6+1
    always_ff @(posedge clk) begin
        outputBot         <= mbfPkg::varSwap(s1Bot, 3'd1, p6D + 3'd1);
        outputBotValid    <= validD;
        botSeriesFinished <= lastD;
    end

endmodule

// File: permutationGenerator67.sv
`timescale 1ns/1ns

module permutationGenerator67 (
    input  logic            clk,
    input  logic            rst,
    input  mbfPkg::mbf_t    head,
    input  logic            notEmpty,
    input  logic            slowDown,
    output logic            pop,
    output mbfPkg::mbf_t    outputBot,
    output logic            outputBotValid,
    output logic            botSeriesFinished
);

    mbfPkg::genState_t state;
    mbfPkg::permut6_t  p6;
    mbfPkg::permut7_t  p7;
    mbfPkg::mbf_t      curBot; // bot of the running series
    logic lastStep;
    logic running;

    assign running = (state == mbfPkg::permuting);
    assign lastStep = running && (p6 == '0) && (p7 == '0);

    // a new series may start from idle or on the last step of the current one,
    // so two series follow each other without a gap
    assign pop = notEmpty && !slowDown && (!running || lastStep);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mbfPkg::idle;
            p6 <= '0;
            p7 <= '0;
        end else if (pop) begin
            state <= mbfPkg::permuting;
            p6 <= mbfPkg::p6First;
            p7 <= mbfPkg::p7First;
        end else if (lastStep) begin
            state <= mbfPkg::idle; // nothing to start, wait
        end else if (running) begin
            // p7 is the inner counter
            if (p7 == '0) begin
                p7 <= mbfPkg::p7First;
                p6 <= p6 - 3'd1;
            end else begin
                p7 <= p7 - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            curBot <= head; // head is consumed in the pop cycle
        end
    end

    permute67 swapPipe (
        .clk                (clk),
        .bot                (curBot),
        .p7                 (p7),
        .p6                 (p6),
        .validIn            (running),
        .lastIn             (lastStep),
        .outputBot          (outputBot),
        .outputBotValid     (outputBotValid),
        .botSeriesFinished  (botSeriesFinished)
    );

endmodule

// File: mbfPermuterTop.sv
`timescale 1ns/1ns

module mbfPermuterTop (
    input  logic            clk,
    input  logic            rst,
    input  mbfPkg::mbf_t    inputBot,
    input  logic            writeInputBot,
    output logic            hasSpaceForNextBot,
    output mbfPkg::mbf_t    outputBot,
    output logic            outputBotValid,
    output logic            botSeriesFinished,
    input  logic            slowDown
);

    mbfPkg::botLink_t link;
    logic             creditReturn;
    mbfPkg::mbf_t     head;
    logic             notEmpty;
    logic             pop;

    botIngress ingress (
        .clk                (clk),
        .rst                (rst),
        .inputBot           (inputBot),
        .writeInputBot      (writeInputBot),
        .creditReturn       (creditReturn),
        .link               (link),
        .hasSpaceForNextBot (hasSpaceForNextBot)
    );

    botFifo buffer (
        .clk            (clk),
        .rst            (rst),
        .link           (link),
        .pop            (pop),
        .head           (head),
        .notEmpty       (notEmpty),
        .creditReturn   (creditReturn)
    );

    // pop to first output is 3 cycles
    permutationGenerator67 generator (
        .clk                (clk),
        .rst                (rst),
        .head               (head),
        .notEmpty           (notEmpty),
        .slowDown           (slowDown),
        .pop                (pop),
        .outputBot          (outputBot),
        .outputBotValid     (outputBotValid),
        .botSeriesFinished  (botSeriesFinished)
    );

endmodule

// File: tbMbfModel.svh
`ifndef TB_MBF_MODEL_SVH
`define TB_MBF_MODEL_SVH

// exchange bits a and b of a truth-table index
function automatic logic [6:0] exchangeBits(input logic [6:0] idx, input int a, input int b);
    logic [6:0] mask;
    mask = (7'd1 << a) | (7'd1 << b);
    return (idx[a] != idx[b]) ? (idx ^ mask) : idx; // equal bits need no exchange
endfunction

// bot with variables 0,p7 swapped and then variables 1,p6+1 swapped
function automatic mbfPkg::mbf_t expectedPermutation(
    input mbfPkg::mbf_t     bot,
    input mbfPkg::permut6_t p6,
    input mbfPkg::permut7_t p7
);
    mbfPkg::mbf_t result;
    logic [6:0]   src;
    for (int i = 0; i < 128; i++) begin
        // the later swap maps the index first
        src = exchangeBits(exchangeBits(7'(i), 1, int'(p6) + 1), 0, int'(p7));
        result[i] = bot[src];
    end
    return result;
endfunction

function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic checkBot(input string name, input mbfPkg::mbf_t expected, input mbfPkg::mbf_t actual);
    if (actual !== expected) begin
        $display("** Error [%s] outputBot expected %h actual %h", name, expected, actual);
        abortSimulation();
    end
endtask

task automatic checkFlag(input string name, input string signal, input logic expected,
                         input logic actual);
    if (actual !== expected) begin
        $display("** Error [%s] %s expected %b actual %b", name, signal, expected, actual);
        abortSimulation();
    end
endtask

`endif

// File: tbMbfPermuter.sv
`timescale 1ns/1ns

module tbMbfPermuter;

    localparam int totalBots = 44;                // 8 + 1 + 3 + 2 + 30
    localparam int slowHoldMax = 60 + 20 + 30 * 16; // worst case slowDown high time
    localparam int cycleLimit = 60 * totalBots + slowHoldMax + 200;

    logic              clk;
    logic              rst;
    mbfPkg::mbf_t      inputBot;
    logic              writeInputBot;
    logic              slowDown;
    logic              hasSpaceForNextBot;
    mbfPkg::mbf_t      outputBot;
    logic              outputBotValid;
    logic              botSeriesFinished;

    mbfPkg::mbf_t      expectQ[$]; // accepted bots, oldest first
    mbfPkg::permut6_t  modelP6;
    mbfPkg::permut7_t  modelP7;
    int                validCount;
    int                cycleCount = 0;
    logic [31:0]       lcgState;
    string             testName;

    mbfPermuterTop DUT (
        .clk                (clk),
        .rst                (rst),
        .inputBot           (inputBot),
        .writeInputBot      (writeInputBot),
        .hasSpaceForNextBot (hasSpaceForNextBot),
        .outputBot          (outputBot),
        .outputBotValid     (outputBotValid),
        .botSeriesFinished  (botSeriesFinished),
        .slowDown           (slowDown)
    );

    always #50 clk = ~clk;

    task automatic abortSimulation();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    `include "tbMbfModel.svh"

    task automatic drawBot(output mbfPkg::mbf_t bot);
        for (int k = 0; k < 4; k++) begin
            lcgState = lcgNext(lcgState);
            bot[32*k +: 32] = lcgState ^ (lcgState >> 15); // fold high bits down
        end
    endtask

    // writes only when a credit is certain, so every write is accepted
    task automatic sendBot(input mbfPkg::mbf_t bot);
        @(posedge clk);
        while (hasSpaceForNextBot !== 1'b1) begin
            @(posedge clk);
        end
        inputBot <= bot;
        writeInputBot <= 1'b1;
        expectQ.push_back(bot);
        @(posedge clk); // taken at this edge
        writeInputBot <= 1'b0;
    endtask

    task automatic waitDrain();
        while (expectQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
    endtask

    task automatic waitSeriesEnd();
        do begin
            @(posedge clk);
        end while (botSeriesFinished !== 1'b1);
    endtask

    // scoreboard whose model indices count down like the generator
    always @(posedge clk) begin
        if (rst === 1'b0) begin
            if (writeInputBot && !hasSpaceForNextBot) begin
                $display("a bot was written while the DUT had no space");
                abortSimulation();
            end
            if (outputBotValid === 1'b1) begin
                if (expectQ.size() == 0) begin
                    $display("valid output while no bot was pending");
                    abortSimulation();
                end
                checkBot(testName, expectedPermutation(expectQ[0], modelP6, modelP7), outputBot);
                checkFlag(testName, "botSeriesFinished", modelP6 == '0 && modelP7 == '0,
                          botSeriesFinished);
                validCount++;
                if (modelP6 == '0 && modelP7 == '0) begin
                    void'(expectQ.pop_front()); // series done
                    modelP6 = 3'd5;
                    modelP7 = 3'd6;
                end else if (modelP7 == '0) begin
                    modelP7 = 3'd6;
                    modelP6 = modelP6 - 3'd1;
                end else begin
                    modelP7 = modelP7 - 3'd1;
                end
            end else begin
                checkFlag(testName, "outputBotValid", 1'b0, outputBotValid);
                checkFlag(testName, "botSeriesFinished", 1'b0, botSeriesFinished);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycleLimit);
            abortSimulation();
        end
    end

    initial begin
        mbfPkg::mbf_t bot;
        logic [31:0]  roll;
        int           seenBefore;
        clk = 1'b0;
        rst = 1'b1;
        inputBot = '0;
        writeInputBot = 1'b0;
        slowDown = 1'b1; // held from reset for the credit test
        lcgState = 32'd9637;
        modelP6 = 3'd5;
        modelP7 = 3'd6;
        validCount = 0;
        testName = "reset";
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkFlag(testName, "outputBotValid", 1'b0, outputBotValid);
        checkFlag(testName, "botSeriesFinished", 1'b0, botSeriesFinished);
        checkFlag(testName, "hasSpaceForNextBot", 1'b1, hasSpaceForNextBot);

        testName = "creditLimit";
        for (int k = 0; k < mbfPkg::fifoDepth; k++) begin
            drawBot(bot);
            sendBot(bot);
            @(posedge clk);
            checkFlag(testName, "hasSpaceForNextBot", k < mbfPkg::fifoDepth - 1,
                      hasSpaceForNextBot);
        end
        repeat (20) begin
            @(posedge clk);
            checkFlag(testName, "hasSpaceForNextBot", 1'b0, hasSpaceForNextBot);
        end
        slowDown <= 1'b0;
        while (hasSpaceForNextBot !== 1'b1) begin
            @(posedge clk);
        end
        // the credit is back two cycles after the pop, one before the first output
        @(posedge clk);
        checkFlag(testName, "outputBotValid", 1'b1, outputBotValid);
        waitDrain();

        testName = "singleBot";
        seenBefore = validCount;
        drawBot(bot);
        sendBot(bot);
        waitDrain();
        if (validCount - seenBefore != 42) begin
            $display("** Error [%s] output count expected 42 actual %0d", testName,
                     validCount - seenBefore);
            abortSimulation();
        end

        testName = "backToBack";
        repeat (3) begin
            drawBot(bot);
            sendBot(bot);
        end
        repeat (2) begin
            waitSeriesEnd();
            @(posedge clk); // next series must already be running
            checkFlag(testName, "outputBotValid", 1'b1, outputBotValid);
        end
        waitDrain();

        testName = "slowGate";
        repeat (2) begin
            drawBot(bot);
            sendBot(bot);
        end
        while (outputBotValid !== 1'b1) begin
            @(posedge clk);
        end
        slowDown <= 1'b1;
        waitSeriesEnd();
        repeat (20) begin
            @(posedge clk);
            checkFlag(testName, "outputBotValid", 1'b0, outputBotValid);
        end
        slowDown <= 1'b0;
        waitDrain();

        testName = "randomStream";
        for (int n = 0; n < 30; n++) begin
            lcgState = lcgNext(lcgState);
            roll = lcgState;
            if (roll[31:30] == 2'b00) begin
                slowDown <= 1'b1; // pulse of 1..16 cycles
                repeat (1 + roll[19:16]) @(posedge clk);
                slowDown <= 1'b0;
            end
            drawBot(bot);
            sendBot(bot);
        end
        waitDrain();

        if (expectQ.size() != 0 || validCount != 42 * totalBots) begin
            $display("bots left %0d, outputs %0d of %0d", expectQ.size(), validCount,
                     42 * totalBots);
            abortSimulation();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+.
mbfPkg.sv
botIngress.sv
botFifo.sv
permute67.sv
permutationGenerator67.sv
mbfPermuterTop.sv
tbMbfPermuter.sv

// File: Makefile
TOP ?= tbMbfPermuter
RTL_TOP ?= mbfPermuterTop
SIM_LOG ?= sim.log
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
OBJ_DIR ?= obj_dir

SOURCES := $(shell cat filelist.f | grep -v '^+') tbMbfModel.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): filelist.f $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) -f filelist.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(SIM_LOG)
	@if grep -q "SIMULATION PASSED" $(SIM_LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(SIM_LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f filelist.f --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
